// ==== source/raster_mem_pkg.sv ====
package raster_mem_pkg;

    // avalon side
    localparam int addr_width = 26;
    localparam int data_width = 32;
    localparam int bytes_per_word = data_width / 8;

    // count word first, then triangles back to back
    localparam int words_per_vertex = 5;
    localparam int words_per_tri = 15;

    // word order inside one vertex with word 4 reserved
    localparam int x_word = 0;
    localparam int y_word = 1;
    localparam int z_word = 2;
    localparam int color_word = 3;

    typedef logic [data_width-1:0] word_t;

    // word i of the triangle sits at index i
    typedef word_t [words_per_tri-1:0] raw_tri_t;

endpackage

// ==== source/raster_geom_pkg.sv ====
package raster_geom_pkg;

    localparam int verts_per_tri = 3;

    // Q12.4 screen coordinates
    localparam int coord_width = 16;
    localparam int frac_bits = 4;
    localparam int area_width = 33;

    // low 16 bits of the Q16.16 input >>> frac_shift
    localparam int frac_shift = 12;

    localparam int screen_w = 640;
    localparam int screen_h = 480;

    typedef logic signed [coord_width-1:0] coord_t;
    typedef logic signed [area_width-1:0] area_t;
    typedef logic [31:0] depth_t;
    typedef logic [31:0] color_t;

    // last valid position on screen in Q12.4
    localparam coord_t screen_max_x = coord_t'((screen_w << frac_bits) - 1);
    localparam coord_t screen_max_y = coord_t'((screen_h << frac_bits) - 1);

    typedef struct packed {
        coord_t x;
        coord_t y;
        depth_t z;
        color_t color;
    } vertex_t;

    typedef vertex_t [verts_per_tri-1:0] tri_t;

    typedef struct packed {
        coord_t min_x;
        coord_t min_y;
        coord_t max_x;
        coord_t max_y;
        area_t area2;
        color_t color0;
    } setup_t;

endpackage

// ==== source/tri_stream_if.sv ====
interface tri_stream_if #(
    parameter type payload_t = logic
);

    logic valid;
    logic ready;
    payload_t payload;
    // final triangle of a batch
    logic last;

    modport source (
        output valid,
        output payload,
        output last,
        input ready
    );

    modport sink (
        input valid,
        input payload,
        input last,
        output ready
    );

endinterface

// ==== source/vertex_fetch.sv ====
module vertex_fetch (
    input logic clock,
    input logic reset,
    input logic start,
    input logic [raster_mem_pkg::addr_width-1:0] base_address,
    output logic busy,
    output logic [raster_mem_pkg::addr_width-1:0] master_address,
    output logic master_read,
    output logic [raster_mem_pkg::bytes_per_word-1:0] master_byteenable,
    input logic [raster_mem_pkg::data_width-1:0] master_readdata,
    input logic master_readdatavalid,
    input logic master_waitrequest,
    output logic empty_batch,
    tri_stream_if.source tri_out
);

    localparam int word_bits = $clog2(raster_mem_pkg::words_per_tri);
    localparam int last_word = raster_mem_pkg::words_per_tri - 1;
    localparam logic [raster_mem_pkg::addr_width-1:0] addr_step =
        raster_mem_pkg::addr_width'(raster_mem_pkg::bytes_per_word);

    typedef enum logic [1:0] {send_idle, send_count, send_wait, send_tri} send_state_t;
    typedef enum logic {recv_count, recv_words} recv_state_t;

    send_state_t send_state;
    recv_state_t recv_state;
    logic [raster_mem_pkg::data_width-1:0] tri_total;
    logic [raster_mem_pkg::data_width-1:0] tri_issued;
    logic [raster_mem_pkg::data_width-1:0] tri_received;
    logic [word_bits-1:0] send_word;
    logic [word_bits-1:0] recv_word;
    logic word_accepted;
    logic word_capture;
    logic in_flight;
    logic handshake;

    assign master_byteenable = '1;
    assign word_accepted = master_read && !master_waitrequest;
    assign word_capture = (recv_state == recv_words) && master_readdatavalid;
    assign handshake = tri_out.valid && tri_out.ready;
    // from the first read of a triangle until it leaves downstream
    assign in_flight = (tri_issued != tri_received) || tri_out.valid;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            send_state <= send_idle;
            master_read <= 1'b0;
            master_address <= '0;
            busy <= 1'b0;
            send_word <= '0;
            tri_issued <= '0;
        end else begin
            case (send_state)
                send_idle: begin
                    if (start) begin
                        busy <= 1'b1;
                        master_address <= base_address;
                        master_read <= 1'b1;
                        tri_issued <= '0;
                        send_state <= send_count;
                    end
                end
                send_count: begin
                    if (word_accepted) begin
                        master_read <= 1'b0;
                        master_address <= master_address + addr_step;
                        send_state <= send_wait;
                    end
                end
                send_wait: begin
                    // back-pressure holds the bus here
                    if (recv_state == recv_words && !in_flight) begin
                        if (tri_issued == tri_total) begin
                            busy <= 1'b0;
                            send_state <= send_idle;
                        end else begin
                            master_read <= 1'b1;
                            send_word <= '0;
                            send_state <= send_tri;
                        end
                    end
                end
                send_tri: begin
                    if (word_accepted) begin
                        master_address <= master_address + addr_step;
                        send_word <= send_word + 1'b1;
                        if (send_word == last_word) begin
                            master_read <= 1'b0;
                            tri_issued <= tri_issued + 1'b1;
                            send_state <= send_wait;
                        end
                    end
                end
                default: send_state <= send_idle;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            recv_state <= recv_count;
            tri_total <= '0;
            tri_received <= '0;
            recv_word <= '0;
            empty_batch <= 1'b0;
            tri_out.valid <= 1'b0;
        end else begin
            empty_batch <= 1'b0;
            if (handshake) begin
                tri_out.valid <= 1'b0;
            end
            case (recv_state)
                recv_count: begin
                    if (master_readdatavalid) begin
                        tri_total <= master_readdata;
                        tri_received <= '0;
                        recv_word <= '0;
                        empty_batch <= (master_readdata == '0);
                        recv_state <= recv_words;
                    end
                end
                recv_words: begin
                    if (start && send_state == send_idle) begin
                        recv_state <= recv_count;
                    end else if (master_readdatavalid) begin
                        recv_word <= recv_word + 1'b1;
                        if (recv_word == last_word) begin
                            recv_word <= '0;
                            tri_received <= tri_received + 1'b1;
                            tri_out.valid <= 1'b1;
                        end
                    end
                end
                default: recv_state <= recv_count;
            endcase
        end
    end

    // gather buffer doubles as the output payload
    always_ff @(posedge clock) begin
        if (word_capture) begin
            tri_out.payload[recv_word] <= master_readdata;
            if (recv_word == last_word) begin
                tri_out.last <= (tri_received + 1'b1 == tri_total);
            end
        end
    end

    assert property (@(posedge clock) disable iff (!reset)
        master_read && master_waitrequest |=> master_read && $stable(master_address));

endmodule

// ==== source/vertex_decode.sv ====
module vertex_decode (
    input logic clock,
    input logic reset,
    tri_stream_if.sink raw_in,
    tri_stream_if.source tri_out
);

    raster_geom_pkg::tri_t decoded;

    // Q16.16 to Q12.4
    function automatic raster_geom_pkg::coord_t to_screen(
        input logic [raster_mem_pkg::data_width-1:0] word
    );
        logic signed [raster_mem_pkg::data_width-1:0] shifted;
        shifted = $signed(word) >>> raster_geom_pkg::frac_shift;
        return raster_geom_pkg::coord_t'(shifted);
    endfunction

    always_comb begin
        for (int v = 0; v < raster_geom_pkg::verts_per_tri; v++) begin
            decoded[v].x = to_screen(
                raw_in.payload[v * raster_mem_pkg::words_per_vertex + raster_mem_pkg::x_word]);
            decoded[v].y = to_screen(
                raw_in.payload[v * raster_mem_pkg::words_per_vertex + raster_mem_pkg::y_word]);
            decoded[v].z =
                raw_in.payload[v * raster_mem_pkg::words_per_vertex + raster_mem_pkg::z_word];
            decoded[v].color =
                raw_in.payload[v * raster_mem_pkg::words_per_vertex + raster_mem_pkg::color_word];
        end
    end

    assign raw_in.ready = !tri_out.valid || tri_out.ready;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            tri_out.valid <= 1'b0;
        end else if (raw_in.ready) begin
            tri_out.valid <= raw_in.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (raw_in.valid && raw_in.ready) begin
            tri_out.payload <= decoded;
            tri_out.last <= raw_in.last;
        end
    end

endmodule

// ==== source/tri_setup.sv ====
module tri_setup (
    input logic clock,
    input logic reset,
    tri_stream_if.sink tri_in,
    tri_stream_if.source setup_out
);

    typedef logic signed [raster_geom_pkg::coord_width:0] diff_t;

    logic advance;
    logic s1_valid;
    logic s1_last;
    diff_t s1_dx1;
    diff_t s1_dy1;
    diff_t s1_dx2;
    diff_t s1_dy2;
    raster_geom_pkg::coord_t s1_min_x;
    raster_geom_pkg::coord_t s1_min_y;
    raster_geom_pkg::coord_t s1_max_x;
    raster_geom_pkg::coord_t s1_max_y;
    raster_geom_pkg::color_t s1_color0;
    logic signed [2 * raster_geom_pkg::coord_width + 2:0] area_full;

    function automatic raster_geom_pkg::coord_t min3(
        input raster_geom_pkg::coord_t a,
        input raster_geom_pkg::coord_t b,
        input raster_geom_pkg::coord_t c
    );
        raster_geom_pkg::coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic raster_geom_pkg::coord_t max3(
        input raster_geom_pkg::coord_t a,
        input raster_geom_pkg::coord_t b,
        input raster_geom_pkg::coord_t c
    );
        raster_geom_pkg::coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // whole pipe freezes on output stall
    assign advance = !setup_out.valid || setup_out.ready;
    assign tri_in.ready = advance;

    // full-width cross product before the wrap to the area type
    assign area_full = s1_dx1 * s1_dy2 - s1_dx2 * s1_dy1;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            s1_valid <= 1'b0;
            setup_out.valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= tri_in.valid;
            setup_out.valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            s1_dx1 <= tri_in.payload[1].x - tri_in.payload[0].x;
            s1_dy1 <= tri_in.payload[1].y - tri_in.payload[0].y;
            s1_dx2 <= tri_in.payload[2].x - tri_in.payload[0].x;
            s1_dy2 <= tri_in.payload[2].y - tri_in.payload[0].y;
            s1_min_x <= min3(tri_in.payload[0].x, tri_in.payload[1].x, tri_in.payload[2].x);
            s1_min_y <= min3(tri_in.payload[0].y, tri_in.payload[1].y, tri_in.payload[2].y);
            s1_max_x <= max3(tri_in.payload[0].x, tri_in.payload[1].x, tri_in.payload[2].x);
            s1_max_y <= max3(tri_in.payload[0].y, tri_in.payload[1].y, tri_in.payload[2].y);
            s1_color0 <= tri_in.payload[0].color;
            s1_last <= tri_in.last;
            setup_out.payload.min_x <= s1_min_x;
            setup_out.payload.min_y <= s1_min_y;
            setup_out.payload.max_x <= s1_max_x;
            setup_out.payload.max_y <= s1_max_y;
            setup_out.payload.area2 <= raster_geom_pkg::area_t'(area_full);
            setup_out.payload.color0 <= s1_color0;
            setup_out.last <= s1_last;
        end
    end

    // a new output needs a triangle accepted two cycles before
    assert property (@(posedge clock) disable iff (!reset)
        $rose(setup_out.valid) |-> $past(tri_in.valid && tri_in.ready, 2));

endmodule

// ==== source/tri_cull.sv ====
module tri_cull (
    input logic clock,
    input logic reset,
    input logic start,
    tri_stream_if.sink setup_in,
    input logic empty_batch,
    output logic out_valid,
    input logic out_ready,
    output raster_geom_pkg::coord_t out_min_x,
    output raster_geom_pkg::coord_t out_min_y,
    output raster_geom_pkg::coord_t out_max_x,
    output raster_geom_pkg::coord_t out_max_y,
    output raster_geom_pkg::area_t out_area,
    output raster_geom_pkg::color_t out_color,
    output logic [15:0] drawn_count,
    output logic [15:0] culled_count,
    output logic done,
    output logic active
);

    logic consume;
    logic off_screen;
    logic keep;
    logic out_last;
    logic done_next;

    function automatic raster_geom_pkg::coord_t clamp(
        input raster_geom_pkg::coord_t value,
        input raster_geom_pkg::coord_t limit
    );
        if (value < 0) begin
            return '0;
        end
        return (value > limit) ? limit : value;
    endfunction

    assign setup_in.ready = !out_valid || out_ready;
    assign consume = setup_in.valid && setup_in.ready;
    assign off_screen = setup_in.payload.max_x < 0 || setup_in.payload.max_y < 0 ||
        setup_in.payload.min_x > raster_geom_pkg::screen_max_x ||
        setup_in.payload.min_y > raster_geom_pkg::screen_max_y;
    // back-facing and degenerate both fail here
    assign keep = setup_in.payload.area2 > 0 && !off_screen;
    assign done_next = (out_valid && out_ready && out_last) ||
        (consume && !keep && setup_in.last) || empty_batch;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            out_valid <= 1'b0;
            out_last <= 1'b0;
            drawn_count <= '0;
            culled_count <= '0;
            done <= 1'b0;
            active <= 1'b0;
        end else begin
            done <= done_next;
            if (start) begin
                active <= 1'b1;
                drawn_count <= '0;
                culled_count <= '0;
            end else if (done_next) begin
                active <= 1'b0;
            end
            if (consume && keep) begin
                out_valid <= 1'b1;
                out_last <= setup_in.last;
                drawn_count <= drawn_count + 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            if (consume && !keep) begin
                culled_count <= culled_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (consume && keep) begin
            out_min_x <= clamp(setup_in.payload.min_x, raster_geom_pkg::screen_max_x);
            out_min_y <= clamp(setup_in.payload.min_y, raster_geom_pkg::screen_max_y);
            out_max_x <= clamp(setup_in.payload.max_x, raster_geom_pkg::screen_max_x);
            out_max_y <= clamp(setup_in.payload.max_y, raster_geom_pkg::screen_max_y);
            out_area <= setup_in.payload.area2;
            out_color <= setup_in.payload.color0;
        end
    end

    assert property (@(posedge clock) disable iff (!reset)
        out_valid && !out_ready |=> out_valid &&
        $stable({out_min_x, out_min_y, out_max_x, out_max_y, out_area, out_color}));

endmodule

// ==== source/raster_setup_top.sv ====
module raster_setup_top (
    input logic clock,
    input logic reset,
    input logic start,
    input logic [raster_mem_pkg::addr_width-1:0] base_address,
    output logic busy,
    output logic done,
    output logic [raster_mem_pkg::addr_width-1:0] master_address,
    output logic master_read,
    output logic [raster_mem_pkg::bytes_per_word-1:0] master_byteenable,
    input logic [raster_mem_pkg::data_width-1:0] master_readdata,
    input logic master_readdatavalid,
    input logic master_waitrequest,
    output logic out_valid,
    input logic out_ready,
    output raster_geom_pkg::coord_t out_min_x,
    output raster_geom_pkg::coord_t out_min_y,
    output raster_geom_pkg::coord_t out_max_x,
    output raster_geom_pkg::coord_t out_max_y,
    output raster_geom_pkg::area_t out_area,
    output raster_geom_pkg::color_t out_color,
    output logic [15:0] drawn_count,
    output logic [15:0] culled_count
);

    logic start_accept;
    logic fetch_busy;
    logic cull_active;
    logic empty_batch;

    tri_stream_if #(.payload_t(raster_mem_pkg::raw_tri_t)) raw_stream ();
    tri_stream_if #(.payload_t(raster_geom_pkg::tri_t)) tri_stream ();
    tri_stream_if #(.payload_t(raster_geom_pkg::setup_t)) setup_stream ();

    // busy until the last triangle has drained through cull
    assign busy = fetch_busy || cull_active;
    assign start_accept = start && !busy;

    vertex_fetch vertex_fetch_i (
        .clock(clock),
        .reset(reset),
        .start(start_accept),
        .base_address(base_address),
        .busy(fetch_busy),
        .master_address(master_address),
        .master_read(master_read),
        .master_byteenable(master_byteenable),
        .master_readdata(master_readdata),
        .master_readdatavalid(master_readdatavalid),
        .master_waitrequest(master_waitrequest),
        .empty_batch(empty_batch),
        .tri_out(raw_stream.source)
    );

    vertex_decode vertex_decode_i (
        .clock(clock),
        .reset(reset),
        .raw_in(raw_stream.sink),
        .tri_out(tri_stream.source)
    );

    tri_setup tri_setup_i (
        .clock(clock),
        .reset(reset),
        .tri_in(tri_stream.sink),
        .setup_out(setup_stream.source)
    );

    tri_cull tri_cull_i (
        .clock(clock),
        .reset(reset),
        .start(start_accept),
        .setup_in(setup_stream.sink),
        .empty_batch(empty_batch),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_min_x(out_min_x),
        .out_min_y(out_min_y),
        .out_max_x(out_max_x),
        .out_max_y(out_max_y),
        .out_area(out_area),
        .out_color(out_color),
        .drawn_count(drawn_count),
        .culled_count(culled_count),
        .done(done),
        .active(cull_active)
    );

endmodule

// ==== dv/avalon_mem_model.sv ====
module avalon_mem_model #(
    parameter int depth_words = 8192
) (
    input logic clock,
    input logic reset,
    input logic [raster_mem_pkg::addr_width-1:0] address,
    input logic read,
    input logic [raster_mem_pkg::bytes_per_word-1:0] byteenable,
    output logic [raster_mem_pkg::data_width-1:0] readdata,
    output logic readdatavalid,
    output logic waitrequest
);

    logic [raster_mem_pkg::data_width-1:0] mem [depth_words];
    logic [raster_mem_pkg::data_width-1:0] data_q[$];
    int due_q[$];
    int seed;
    int cycle;
    int last_due;
    int due;

    initial begin
        seed = 32'h2076ea02;
        cycle = 0;
        last_due = 0;
        readdata = '0;
        readdatavalid = 1'b0;
        waitrequest = 1'b0;
        // fill tied to the full byte address
        for (int i = 0; i < depth_words; i++) begin
            mem[i] = 32'hc3a50000 ^ ((i * 4) * 32'h00010001);
        end
    end

    always @(posedge clock) begin
        if (!reset) begin
            data_q.delete();
            due_q.delete();
            last_due = 0;
            #1;
            readdatavalid = 1'b0;
            waitrequest = 1'b0;
        end else begin
            cycle++;
            if (read && !waitrequest) begin
                // in-order return after 1 to 3 cycles
                due = cycle + 1 + ($unsigned($random(seed)) % 3);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                data_q.push_back(mem[address[14:2]]);
                due_q.push_back(due);
            end
            #1;
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                readdatavalid = 1'b1;
                readdata = data_q.pop_front();
                void'(due_q.pop_front());
            end else begin
                readdatavalid = 1'b0;
            end
            waitrequest = ($random(seed) & 3) == 0;
        end
    end

endmodule

// ==== dv/raster_setup_tb.sv ====
module raster_setup_tb;

    localparam int stall_read_limit = 5 * raster_mem_pkg::words_per_tri;
    localparam int timeout_cycles = 5 * 200 + 40 * (20 + 20 + 0 + 20 + 10 + 12);
    localparam int screen_x_limit = (raster_geom_pkg::screen_w << raster_geom_pkg::frac_bits) - 1;
    localparam int screen_y_limit = (raster_geom_pkg::screen_h << raster_geom_pkg::frac_bits) - 1;

    logic clock = 1'b0;
    logic reset;
    logic start;
    logic [raster_mem_pkg::addr_width-1:0] base_address;
    logic busy;
    logic done;
    logic [raster_mem_pkg::addr_width-1:0] master_address;
    logic master_read;
    logic [raster_mem_pkg::bytes_per_word-1:0] master_byteenable;
    logic [raster_mem_pkg::data_width-1:0] master_readdata;
    logic master_readdatavalid;
    logic master_waitrequest;
    logic out_valid;
    logic out_ready;
    raster_geom_pkg::coord_t out_min_x;
    raster_geom_pkg::coord_t out_min_y;
    raster_geom_pkg::coord_t out_max_x;
    raster_geom_pkg::coord_t out_max_y;
    raster_geom_pkg::area_t out_area;
    raster_geom_pkg::color_t out_color;
    logic [15:0] drawn_count;
    logic [15:0] culled_count;

    raster_geom_pkg::setup_t exp_q[$];
    raster_geom_pkg::setup_t expected;
    raster_geom_pkg::setup_t held_out;
    int seed;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int exp_drawn;
    int exp_culled;
    int region_lo;
    int region_hi;
    int ready_random = 0;
    int hold_left = 0;
    int reads_in_stall = 0;
    logic was_stalled = 1'b0;
    logic valid_seen;

    always #5 clock = ~clock;

    raster_setup_top raster_setup_top_i (.*);

    avalon_mem_model mem_model_i (
        .clock(clock),
        .reset(reset),
        .address(master_address),
        .read(master_read),
        .byteenable(master_byteenable),
        .readdata(master_readdata),
        .readdatavalid(master_readdatavalid),
        .waitrequest(master_waitrequest)
    );

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        checks++;
        assert (exp == got) else begin
            errors++;
            $display("ERR %s expected %h got %h", name, exp, got);
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // Q16.16 word with a random fraction
    function automatic logic [31:0] make_word(input int pix);
        return (pix << 16) | ($random(seed) & 32'h0000ffff);
    endfunction

    function automatic int to_q124(input logic [31:0] word);
        logic signed [31:0] s;
        s = $signed(word) >>> raster_geom_pkg::frac_shift;
        return int'($signed(s[15:0]));
    endfunction

    function automatic longint tri_area(input logic [31:0] w [15]);
        longint x0;
        longint y0;
        longint x1;
        longint y1;
        longint x2;
        longint y2;
        x0 = to_q124(w[0]);
        y0 = to_q124(w[1]);
        x1 = to_q124(w[5]);
        y1 = to_q124(w[6]);
        x2 = to_q124(w[10]);
        y2 = to_q124(w[11]);
        return (x1 - x0) * (y2 - y0) - (x2 - x0) * (y1 - y0);
    endfunction

    function automatic int clamp_to(input int value, input int limit);
        if (value < 0) begin
            return 0;
        end
        return (value > limit) ? limit : value;
    endfunction

    task automatic model_tri(input logic [31:0] w [15]);
        int xs[3];
        int ys[3];
        int min_x;
        int min_y;
        int max_x;
        int max_y;
        longint area;
        logic [32:0] area33;
        logic off;
        raster_geom_pkg::setup_t e;
        for (int v = 0; v < 3; v++) begin
            xs[v] = to_q124(w[v * 5]);
            ys[v] = to_q124(w[v * 5 + 1]);
        end
        min_x = xs[0];
        max_x = xs[0];
        min_y = ys[0];
        max_y = ys[0];
        for (int v = 1; v < 3; v++) begin
            min_x = (xs[v] < min_x) ? xs[v] : min_x;
            max_x = (xs[v] > max_x) ? xs[v] : max_x;
            min_y = (ys[v] < min_y) ? ys[v] : min_y;
            max_y = (ys[v] > max_y) ? ys[v] : max_y;
        end
        area = tri_area(w);
        area33 = area[32:0];
        off = max_x < 0 || max_y < 0 || min_x > screen_x_limit || min_y > screen_y_limit;
        if ($signed(area33) > 0 && !off) begin
            e.min_x = 16'(clamp_to(min_x, screen_x_limit));
            e.min_y = 16'(clamp_to(min_y, screen_y_limit));
            e.max_x = 16'(clamp_to(max_x, screen_x_limit));
            e.max_y = 16'(clamp_to(max_y, screen_y_limit));
            e.area2 = area33;
            e.color0 = w[3];
            exp_q.push_back(e);
            exp_drawn++;
        end else begin
            exp_culled++;
        end
    endtask

    // kind 0 random, 1 back-facing, 2 degenerate, 3 off screen
    task automatic write_tri(input int kind, input int word_index);
        int px[3];
        int py[3];
        logic [31:0] w [15];
        logic [31:0] t;
        for (int v = 0; v < 3; v++) begin
            px[v] = (kind == 3) ? rand_range(700, 900) : rand_range(-40, 679);
            py[v] = (kind == 3) ? rand_range(0, 479) : rand_range(-40, 519);
            w[v * 5] = make_word(px[v]);
            w[v * 5 + 1] = make_word(py[v]);
            w[v * 5 + 2] = $random(seed);
            w[v * 5 + 3] = $random(seed);
            w[v * 5 + 4] = $random(seed);
        end
        if (kind == 2) begin
            w[10] = w[0];
            w[11] = w[1];
        end
        // mirror by swapping vertex 1 and 2
        if (kind == 1 && tri_area(w) > 0) begin
            for (int i = 0; i < 5; i++) begin
                t = w[5 + i];
                w[5 + i] = w[10 + i];
                w[10 + i] = t;
            end
        end
        for (int i = 0; i < 15; i++) begin
            mem_model_i.mem[word_index + i] = w[i];
        end
        model_tri(w);
    endtask

    task automatic run_batch(input int base, input int n, input logic mixed,
                             input logic busy_start, input logic check_clear);
        exp_q.delete();
        exp_drawn = 0;
        exp_culled = 0;
        valid_seen = 1'b0;
        mem_model_i.mem[base / 4] = n;
        for (int t = 0; t < n; t++) begin
            write_tri(mixed ? rand_range(0, 3) : 0, base / 4 + 1 + t * 15);
        end
        region_lo = base;
        region_hi = base + 4 * (1 + 15 * n);
        @(posedge clock);
        #1;
        start = 1'b1;
        base_address = base;
        @(posedge clock);
        #1;
        start = 1'b0;
        @(posedge clock);
        check_value("busy", 1, busy);
        if (check_clear) begin
            check_value("drawn_count", 0, drawn_count);
            check_value("culled_count", 0, culled_count);
        end
        if (busy_start) begin
            repeat (30) @(posedge clock);
            check_value("busy", 1, busy);
            #1;
            start = 1'b1;
            base_address = base + 'h1000;
            @(posedge clock);
            #1;
            start = 1'b0;
        end
        do @(posedge clock); while (!done);
        checks++;
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("batch ended with %0d expected triangles never output", exp_q.size());
        end
        check_value("drawn_count", exp_drawn, drawn_count);
        check_value("culled_count", exp_culled, culled_count);
        check_value("busy", 0, busy);
        @(posedge clock);
        check_value("done", 0, done);
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    always @(posedge clock) begin
        #1;
        if (hold_left > 0) begin
            out_ready = 1'b0;
            hold_left--;
        end else if (ready_random != 0) begin
            out_ready = $random(seed);
        end else begin
            out_ready = 1'b1;
        end
    end

    // output, stall and bus monitor
    always @(posedge clock) begin
        if (reset) begin
            if (out_valid) begin
                valid_seen = 1'b1;
            end
            if (was_stalled) begin
                check_value("out_valid", 1, out_valid);
                check_value("out_min_x", held_out.min_x, out_min_x);
                check_value("out_min_y", held_out.min_y, out_min_y);
                check_value("out_max_x", held_out.max_x, out_max_x);
                check_value("out_max_y", held_out.max_y, out_max_y);
                check_value("out_area", held_out.area2, out_area);
                check_value("out_color", held_out.color0, out_color);
            end
            if (out_valid && out_ready) begin
                checks++;
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("output triangle appeared with none expected");
                end
                if (exp_q.size() > 0) begin
                    expected = exp_q.pop_front();
                    check_value("out_min_x", expected.min_x, out_min_x);
                    check_value("out_min_y", expected.min_y, out_min_y);
                    check_value("out_max_x", expected.max_x, out_max_x);
                    check_value("out_max_y", expected.max_y, out_max_y);
                    check_value("out_area", expected.area2, out_area);
                    check_value("out_color", expected.color0, out_color);
                end
            end
            if (master_read && !master_waitrequest) begin
                check_value("master_byteenable", 4'hf, master_byteenable);
                checks++;
                assert (master_address >= region_lo && master_address < region_hi) else begin
                    errors++;
                    $display("read address %h outside the active batch", master_address);
                end
                if (out_valid && !out_ready) begin
                    reads_in_stall++;
                end
            end
            if (!(out_valid && !out_ready)) begin
                reads_in_stall = 0;
            end
            checks++;
            assert (reads_in_stall <= stall_read_limit) else begin
                errors++;
                $display("bus reads continued while the output stayed stalled");
            end
            was_stalled = out_valid && !out_ready;
            held_out = {out_min_x, out_min_y, out_max_x, out_max_y, out_area, out_color};
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > timeout_cycles) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int errors_before;
        seed = 32'h2076ea02;
        reset = 1'b0;
        start = 1'b0;
        base_address = '0;
        out_ready = 1'b1;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b1;

        errors_before = errors;
        run_batch('h0100, 20, 1'b0, 1'b0, 1'b1);
        report_test("1 random batch, ready high", errors_before);

        errors_before = errors;
        ready_random = 1;
        hold_left = 150;
        run_batch('h1000, 20, 1'b0, 1'b0, 1'b1);
        ready_random = 0;
        report_test("2 random batch, random ready", errors_before);

        errors_before = errors;
        run_batch('h3000, 0, 1'b0, 1'b0, 1'b1);
        checks++;
        assert (!valid_seen) else begin
            errors++;
            $display("out_valid rose during an empty batch");
        end
        report_test("3 empty batch", errors_before);

        errors_before = errors;
        run_batch('h4000, 20, 1'b1, 1'b0, 1'b1);
        report_test("4 mixed cull batch", errors_before);

        errors_before = errors;
        run_batch('h2000, 10, 1'b1, 1'b1, 1'b1);
        run_batch('h6000, 12, 1'b1, 1'b1, 1'b1);
        report_test("5 back to back batches", errors_before);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
source/raster_mem_pkg.sv
source/raster_geom_pkg.sv
source/tri_stream_if.sv
source/vertex_fetch.sv
source/vertex_decode.sv
source/tri_setup.sv
source/tri_cull.sv
source/raster_setup_top.sv
dv/avalon_mem_model.sv
dv/raster_setup_tb.sv

// ==== Makefile ====
TOP = raster_setup_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o sim

run: compile
	./obj_dir/sim | tee /dev/stderr | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
